/* rtl/nice_mm_cfg.svh */
// Fixed 4x4 array with a 3x4 B matrix; NICE_CALC_CYCLES must equal NICE_B_ROWS + 2*NICE_DIM - 1
`ifndef NICE_MM_CFG_SVH
`define NICE_MM_CFG_SVH

// Data and address width of the core
`define NICE_XLEN 32

// Instruction fields of the matrix instructions
`define NICE_OP_CUSTOM3 7'h7b
`define NICE_F3_MM 3'b010
`define NICE_F7_LOADA 7'b0001000
`define NICE_F7_LOADB 7'b0001001
`define NICE_F7_CALC 7'b0001010

// Array side, also rows and columns of A
`define NICE_DIM 4
// Rows of B and of C
`define NICE_B_ROWS 3
// Byte step between words in memory
`define NICE_WORD_BYTES 4
// Length of the compute phase in cycles
`define NICE_CALC_CYCLES 10

`endif

/* rtl/nice_mm_pkg.sv */
// Types only; all sizes follow nice_mm_cfg.svh, so change the array there and nowhere else
`default_nettype none

`include "nice_mm_cfg.svh"

package nice_mm_pkg;

  // Signed data word, arithmetic wraps modulo 2^32
  typedef logic signed [`NICE_XLEN-1:0] word_t;
  // One word per array row or column
  typedef word_t [`NICE_DIM-1:0] vec_t;

  // Index widths of the datapath control
  localparam int buf_idx_w = $clog2(`NICE_DIM * `NICE_DIM);
  localparam int pre_step_w = $clog2(`NICE_DIM);
  localparam int feed_step_w = $clog2(`NICE_CALC_CYCLES);
  localparam int res_idx_w = $clog2(`NICE_B_ROWS * `NICE_DIM);

  //////////////////////////////////////////////////
  // Core and memory bus payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [`NICE_XLEN-1:0] inst;
    logic [`NICE_XLEN-1:0] rs1;
  } nice_req_t;

  typedef struct packed {
    logic err;
  } nice_rsp_t;

  typedef struct packed {
    logic [`NICE_XLEN-1:0] addr;
    logic read;
    word_t wdata;
  } icb_cmd_t;

  typedef struct packed {
    word_t rdata;
    logic err;
  } icb_rsp_t;

  // Operation state of the controller
  typedef enum logic [2:0] {
    op_idle,
    op_load_a,
    op_load_b,
    op_preload,
    op_calc,
    op_store,
    op_respond
  } mm_op_e;

  // Datapath control from the controller
  typedef struct packed {
    logic a_we;
    logic b_we;
    logic [buf_idx_w-1:0] buf_idx;
    logic preload;
    logic [pre_step_w-1:0] pre_step;
    logic feed;
    logic [feed_step_w-1:0] feed_step;
    logic [res_idx_w-1:0] res_idx;
  } dp_ctrl_t;

endpackage

`default_nettype wire

/* rtl/nice_mm_pe.sv */
// Products and sums wrap at 32 bits; the weight changes only while preload is high
`timescale 1ns/100ps
`default_nettype none

module nice_mm_pe import nice_mm_pkg::*; (
  input  logic  nice_clk,
  input  logic  nice_rst_n,
  input  logic  preload,
  input  word_t weight_in,
  input  word_t act_in,
  input  word_t psum_in,
  output word_t weight_out,
  output word_t act_out,
  output word_t psum_out
);

  word_t weight_q;
  word_t act_q;
  word_t psum_q;

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      weight_q <= '0;
      act_q <= '0;
      psum_q <= '0;
    end else begin
      // Weight shifts down one row per preload cycle
      if (preload) begin
        weight_q <= weight_in;
      end
      act_q <= act_in;
      psum_q <= psum_in + act_in * weight_q;
    end
  end

  assign weight_out = weight_q;
  assign act_out = act_q;
  assign psum_out = psum_q;

endmodule

`default_nettype wire

/* rtl/nice_mm_array.sv */
// Square NICE_DIM grid; inputs are expected pre-skewed by the caller and bottom sums leave unskewed
`timescale 1ns/100ps
`default_nettype none

`include "nice_mm_cfg.svh"

module nice_mm_array import nice_mm_pkg::*; (
  input  logic nice_clk,
  input  logic nice_rst_n,
  input  logic preload,
  input  vec_t weight_in,
  input  vec_t act_in,
  output vec_t psum_out
);

  // Vertical weight and sum links, horizontal activation links
  word_t w_bus [`NICE_DIM+1][`NICE_DIM];
  word_t p_bus [`NICE_DIM+1][`NICE_DIM];
  word_t a_bus [`NICE_DIM][`NICE_DIM+1];

  for (genvar c = 0; c < `NICE_DIM; c++) begin : g_col_edge
    assign w_bus[0][c] = weight_in[c];
    // Sums start from zero at the top
    assign p_bus[0][c] = '0;
    assign psum_out[c] = p_bus[`NICE_DIM][c];
  end

  for (genvar r = 0; r < `NICE_DIM; r++) begin : g_row
    assign a_bus[r][0] = act_in[r];
    for (genvar c = 0; c < `NICE_DIM; c++) begin : g_col
      nice_mm_pe pe_i (
        .nice_clk   (nice_clk),
        .nice_rst_n (nice_rst_n),
        .preload    (preload),
        .weight_in  (w_bus[r][c]),
        .act_in     (a_bus[r][c]),
        .psum_in    (p_bus[r][c]),
        .weight_out (w_bus[r+1][c]),
        .act_out    (a_bus[r][c+1]),
        .psum_out   (p_bus[r+1][c])
      );
    end
  end

endmodule

`default_nettype wire

/* rtl/nice_mm_datapath.sv */
// C is valid only after a full compute phase; A and B buffers keep their last loaded contents
`timescale 1ns/100ps
`default_nettype none

`include "nice_mm_cfg.svh"

module nice_mm_datapath import nice_mm_pkg::*; (
  input  logic     nice_clk,
  input  logic     nice_rst_n,
  input  dp_ctrl_t dp_ctrl,
  input  word_t    rdata,
  output word_t    result
);

  localparam int dim = `NICE_DIM;
  localparam int b_rows = `NICE_B_ROWS;
  localparam int c_words = b_rows * dim;

  // Row-major matrix buffers
  word_t a_buf [dim*dim];
  word_t b_buf [c_words];
  word_t c_buf [c_words];

  vec_t weight_vec;
  vec_t act_vec;
  vec_t psum_vec;

  //////////////////////////////////////////////////
  // Operand buffers
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk) begin
    if (dp_ctrl.a_we) begin
      a_buf[dp_ctrl.buf_idx] <= rdata;
    end
    if (dp_ctrl.b_we) begin
      b_buf[dp_ctrl.buf_idx] <= rdata;
    end
  end

  // Preload presents the bottom row of A first
  // so row k settles in array row k after dim steps
  always_comb begin
    for (int c = 0; c < dim; c++) begin
      weight_vec[c] = a_buf[(dim - 1 - dp_ctrl.pre_step) * dim + c];
    end
  end

  //////////////////////////////////////////////////
  // Skewed activation feed
  //////////////////////////////////////////////////
  // Array row k gets B[i][k] at step i + k
  // zero outside that window and outside calc
  always_comb begin
    for (int r = 0; r < dim; r++) begin
      act_vec[r] = '0;
      if (dp_ctrl.feed && (dp_ctrl.feed_step >= r) && (dp_ctrl.feed_step < r + b_rows)) begin
        act_vec[r] = b_buf[(dp_ctrl.feed_step - r) * dim + r];
      end
    end
  end

  nice_mm_array array_i (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .preload    (dp_ctrl.preload),
    .weight_in  (weight_vec),
    .act_in     (act_vec),
    .psum_out   (psum_vec)
  );

  //////////////////////////////////////////////////
  // Result capture
  //////////////////////////////////////////////////
  // Column j carries C[i][j] at its bottom in step i + j + dim
  // skew of the feed plus the depth of the array
  always_ff @(posedge nice_clk) begin
    if (dp_ctrl.feed) begin
      for (int c = 0; c < dim; c++) begin
        if ((dp_ctrl.feed_step >= c + dim) && (dp_ctrl.feed_step < c + dim + b_rows)) begin
          c_buf[(dp_ctrl.feed_step - c - dim) * dim + c] <= psum_vec[c];
        end
      end
    end
  end

  // Read port for the store commands
  assign result = (dp_ctrl.res_idx < c_words) ? c_buf[dp_ctrl.res_idx] : '0;

endmodule

`default_nettype wire

/* rtl/nice_mm_ctrl.sv */
// Handles one instruction at a time; unknown instructions answer with err set and touch no memory
`timescale 1ns/100ps
`default_nettype none

`include "nice_mm_cfg.svh"

module nice_mm_ctrl import nice_mm_pkg::*; (
  input  logic      nice_clk,
  input  logic      nice_rst_n,
  input  logic      req_valid,
  output logic      req_ready,
  input  nice_req_t req,
  output logic      rsp_valid,
  input  logic      rsp_ready,
  output nice_rsp_t rsp,
  output logic      icb_cmd_valid,
  input  logic      icb_cmd_ready,
  output icb_cmd_t  icb_cmd,
  input  logic      icb_rsp_valid,
  input  logic      icb_rsp_err,
  input  word_t     result,
  output dp_ctrl_t  dp_ctrl,
  output logic      active,
  output logic      mem_holdup
);

  localparam int a_words = `NICE_DIM * `NICE_DIM;
  localparam int b_words = `NICE_B_ROWS * `NICE_DIM;
  localparam int cnt_w = $clog2(a_words + 1);

  mm_op_e                 state_q;
  logic [cnt_w-1:0]       cmd_cnt_q;
  logic [cnt_w-1:0]       rsp_cnt_q;
  logic [cnt_w-1:0]       xfer_words;
  logic [feed_step_w-1:0] step_q;
  logic [`NICE_XLEN-1:0]  base_q;
  logic                   err_q;
  logic [6:0]             opcode;
  logic [2:0]             func3;
  logic [6:0]             func7;
  logic                   is_mm;
  logic                   req_hs;
  logic                   cmd_hs;
  logic                   last_rsp;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign opcode = req.inst[6:0];
  assign func3 = req.inst[14:12];
  assign func7 = req.inst[31:25];
  assign is_mm = (opcode == `NICE_OP_CUSTOM3) && (func3 == `NICE_F3_MM);

  assign req_hs = req_valid & req_ready;
  assign cmd_hs = icb_cmd_valid & icb_cmd_ready;

  // Load B and store both move 12 words
  assign xfer_words = (state_q == op_load_a) ? cnt_w'(a_words) : cnt_w'(b_words);
  assign last_rsp = icb_rsp_valid && (rsp_cnt_q == xfer_words - 1'b1);

  //////////////////////////////////////////////////
  // Operation FSM and transfer counters
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      state_q <= op_idle;
      cmd_cnt_q <= '0;
      rsp_cnt_q <= '0;
      step_q <= '0;
      err_q <= 1'b0;
    end else begin
      // Commands and responses counted apart, several may be in flight
      if (cmd_hs) begin
        cmd_cnt_q <= cmd_cnt_q + 1'b1;
      end
      if (icb_rsp_valid) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
        err_q <= err_q | icb_rsp_err;
      end
      case (state_q)
        op_idle: begin
          if (req_hs) begin
            cmd_cnt_q <= '0;
            rsp_cnt_q <= '0;
            step_q <= '0;
            err_q <= 1'b0;
            if (is_mm && func7 == `NICE_F7_LOADA) begin
              state_q <= op_load_a;
            end else if (is_mm && func7 == `NICE_F7_LOADB) begin
              state_q <= op_load_b;
            end else if (is_mm && func7 == `NICE_F7_CALC) begin
              state_q <= op_calc;
            end else begin
              // Unsupported instruction
              state_q <= op_respond;
              err_q <= 1'b1;
            end
          end
        end
        op_load_a: begin
          if (last_rsp) begin
            state_q <= op_respond;
          end
        end
        op_load_b: begin
          if (last_rsp) begin
            state_q <= op_preload;
            step_q <= '0;
          end
        end
        // One weight row per step
        op_preload: begin
          if (step_q == feed_step_w'(`NICE_DIM - 1)) begin
            state_q <= op_respond;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        op_calc: begin
          if (step_q == feed_step_w'(`NICE_CALC_CYCLES - 1)) begin
            state_q <= op_store;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        op_store: begin
          if (last_rsp) begin
            state_q <= op_respond;
          end
        end
        op_respond: begin
          if (rsp_ready) begin
            state_q <= op_idle;
          end
        end
        default: state_q <= op_idle;
      endcase
    end
  end

  // Base address of the current operation
  always_ff @(posedge nice_clk) begin
    if (req_hs) begin
      base_q <= req.rs1;
    end
  end

  //////////////////////////////////////////////////
  // Memory command, core response and status
  //////////////////////////////////////////////////
  assign icb_cmd_valid = ((state_q == op_load_a) || (state_q == op_load_b) ||
                          (state_q == op_store)) && (cmd_cnt_q < xfer_words);

  always_comb begin
    icb_cmd.addr = base_q + `NICE_XLEN'(cmd_cnt_q) * `NICE_XLEN'(`NICE_WORD_BYTES);
    icb_cmd.read = (state_q != op_store);
    // Write data only in store, bus stays quiet on reads
    icb_cmd.wdata = (state_q == op_store) ? result : '0;
  end

  assign rsp_valid = (state_q == op_respond);
  assign rsp.err = err_q;
  assign req_ready = (state_q == op_idle);
  assign active = (state_q == op_idle) ? req_valid : 1'b1;
  assign mem_holdup = (state_q == op_load_a) || (state_q == op_load_b) ||
                      (state_q == op_calc) || (state_q == op_store);

  // Response count picks the buffer slot, command count the C word
  always_comb begin
    dp_ctrl.a_we = (state_q == op_load_a) & icb_rsp_valid;
    dp_ctrl.b_we = (state_q == op_load_b) & icb_rsp_valid;
    dp_ctrl.buf_idx = rsp_cnt_q[buf_idx_w-1:0];
    dp_ctrl.preload = (state_q == op_preload);
    dp_ctrl.pre_step = step_q[pre_step_w-1:0];
    dp_ctrl.feed = (state_q == op_calc);
    dp_ctrl.feed_step = step_q;
    dp_ctrl.res_idx = cmd_cnt_q[res_idx_w-1:0];
  end

endmodule

`default_nettype wire

/* rtl/nice_mm_top.sv */
// Memory must take no back-pressure on responses and return them in command order
`timescale 1ns/100ps
`default_nettype none

module nice_mm_top import nice_mm_pkg::*; (
  input  logic      nice_clk,
  input  logic      nice_rst_n,
  // Core request
  input  logic      req_valid,
  output logic      req_ready,
  input  nice_req_t req,
  // Core response
  output logic      rsp_valid,
  input  logic      rsp_ready,
  output nice_rsp_t rsp,
  // Memory command
  output logic      icb_cmd_valid,
  input  logic      icb_cmd_ready,
  output icb_cmd_t  icb_cmd,
  // Memory response, always accepted
  input  logic      icb_rsp_valid,
  input  icb_rsp_t  icb_rsp,
  // Core status
  output logic      active,
  output logic      mem_holdup
);

  // Controller to datapath
  dp_ctrl_t dp_ctrl;
  // C word picked by the result index
  word_t    result;

  //////////////////////////////////////////////////
  // Sequencing and bus handshakes
  //////////////////////////////////////////////////
  nice_mm_ctrl ctrl_i (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_err   (icb_rsp.err),
    .result        (result),
    .dp_ctrl       (dp_ctrl),
    .active        (active),
    .mem_holdup    (mem_holdup)
  );

  // Buffers and systolic array, read data goes straight in
  nice_mm_datapath datapath_i (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .dp_ctrl    (dp_ctrl),
    .rdata      (icb_rsp.rdata),
    .result     (result)
  );

endmodule

`default_nettype wire

/* verif/nice_mm_clkgen.sv */
// Free-running 8 ns clock from time 0; reset is released once, after 4 rising edges
`timescale 1ns/100ps
`default_nettype none

module nice_mm_clkgen (
  output logic nice_clk,
  output logic nice_rst_n
);

  // Half period of 4 ns
  initial begin
    nice_clk = 1'b0;
    forever #4 nice_clk = ~nice_clk;
  end

  // Reset low for 4 cycles, released on a rising edge
  initial begin
    nice_rst_n = 1'b0;
    repeat (4) @(posedge nice_clk);
    nice_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/nice_mm_assertions.sv */
// Bound into nice_mm_top; all checks sample on the rising clock, only the reset check runs in reset
`timescale 1ns/100ps
`default_nettype none

module nice_mm_assertions import nice_mm_pkg::*; (
  input logic      nice_clk,
  input logic      nice_rst_n,
  input logic      req_ready,
  input logic      rsp_valid,
  input logic      rsp_ready,
  input nice_rsp_t rsp,
  input logic      icb_cmd_valid,
  input logic      icb_cmd_ready,
  input icb_cmd_t  icb_cmd,
  input logic      mem_holdup
);

  //////////////////////////////////////////////////
  // Handshake hold rules
  //////////////////////////////////////////////////
  // Core response stays up with a stable flag until taken
  rsp_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("core response dropped or changed before rsp_ready");

  // Memory command stays up and unchanged until accepted
  cmd_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid && $stable(icb_cmd))
    else $error("memory command dropped or changed before icb_cmd_ready");

  // No new instruction while a response waits
  rsp_blocks_req: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    rsp_valid |-> !req_ready)
    else $error("req_ready high while a response is pending");

  // Outputs stay quiet in reset
  reset_quiet: assert property (@(posedge nice_clk)
    !nice_rst_n |-> !rsp_valid && !icb_cmd_valid && !mem_holdup)
    else $error("handshake or status output active during reset");

endmodule

`default_nettype wire

/* verif/nice_mm_tb.sv */
// Run from the project root so verif/nice_mm_input.txt is found; stops at the first mismatch
`timescale 1ns/100ps
`default_nettype none

`include "nice_mm_cfg.svh"

module nice_mm_tb
  import nice_mm_pkg::*;
();

  localparam int dim = `NICE_DIM;
  localparam int a_words = dim * dim;
  localparam int c_words = `NICE_B_ROWS * dim;
  // Word offsets inside the data file
  localparam int a_off = 4;
  localparam int b_off = a_off + a_words;
  localparam int c_off = b_off + c_words;
  localparam int timeout_cycles = 400;

  // Pending memory responses with the oldest at the head
  typedef struct packed {
    word_t       rdata;
    logic        err;
    int unsigned due;
  } pend_t;

  logic      nice_clk;
  logic      nice_rst_n;
  logic      req_valid;
  logic      req_ready;
  nice_req_t req;
  logic      rsp_valid;
  logic      rsp_ready;
  nice_rsp_t rsp;
  logic      icb_cmd_valid;
  logic      icb_cmd_ready;
  icb_cmd_t  icb_cmd;
  logic      icb_rsp_valid;
  icb_rsp_t  icb_rsp;
  logic      active;
  logic      mem_holdup;

  word_t       stim [0:c_off+c_words-1];
  word_t       mem [logic [31:0]];
  pend_t       pend_q [$];
  logic [31:0] rd_addr_q [$];
  logic [31:0] wr_addr_q [$];
  word_t       wr_data_q [$];
  int unsigned cyc = 0;
  int          read_cnt = 0;
  int          inject_idx = -1;
  bit          stall_en = 1'b0;
  bit          cmd_seen = 1'b0;
  logic [31:0] a_base;
  logic [31:0] b_base;
  logic [31:0] c_base;
  int          rsp_cycles;

  nice_mm_clkgen clkgen_i (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n)
  );

  nice_mm_top dut_i (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp       (icb_rsp),
    .active        (active),
    .mem_holdup    (mem_holdup)
  );

  bind nice_mm_top nice_mm_assertions assertions_i (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .mem_holdup    (mem_holdup)
  );

  // Words outside A, B and C read back as a pattern of the full address
  function automatic word_t unmapped_word(input logic [31:0] addr);
    return addr ^ 32'h5ac3_3ca5;
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  // In-order responses at most one per cycle after a latency of 1 to 4 cycles
  always @(posedge nice_clk) begin
    pend_t entry;
    cyc++;
    if (icb_cmd_valid) begin
      cmd_seen = 1'b1;
    end
    if (icb_cmd_valid && icb_cmd_ready) begin
      entry.rdata = '0;
      entry.err = 1'b0;
      if (icb_cmd.read) begin
        rd_addr_q.push_back(icb_cmd.addr);
        entry.rdata = mem.exists(icb_cmd.addr) ? mem[icb_cmd.addr] : unmapped_word(icb_cmd.addr);
        // Error injection counts reads of the current operation
        entry.err = (read_cnt == inject_idx);
        read_cnt++;
      end else begin
        mem[icb_cmd.addr] = icb_cmd.wdata;
        wr_addr_q.push_back(icb_cmd.addr);
        wr_data_q.push_back(icb_cmd.wdata);
      end
      entry.due = cyc + (stall_en ? 1 + ($urandom % 4) : 1);
      pend_q.push_back(entry);
    end
    if ((pend_q.size() > 0) && (pend_q[0].due <= cyc)) begin
      entry = pend_q.pop_front();
      icb_rsp_valid <= 1'b1;
      icb_rsp.rdata <= entry.rdata;
      icb_rsp.err <= entry.err;
    end else begin
      icb_rsp_valid <= 1'b0;
      icb_rsp <= '0;
    end
    // Command stalls about one cycle in three when enabled
    icb_cmd_ready <= stall_en ? (($urandom % 3) != 0) : 1'b1;
  end

  //////////////////////////////////////////////////
  // Checks and sequences
  //////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("Timed out after %0d cycles waiting for %s", timeout_cycles, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped on a timeout");
  endtask

  task automatic clear_logs;
    rd_addr_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    read_cnt = 0;
    cmd_seen = 1'b0;
  endtask

  // Issue one instruction and take its response; called on a rising edge
  task automatic run_instr(input logic [6:0] func7, input logic [31:0] rs1,
                           input logic exp_err, input logic busy_check,
                           output int cycles);
    int waited;
    int hold;
    req.inst <= {func7, 5'd2, 5'd1, `NICE_F3_MM, 5'd3, `NICE_OP_CUSTOM3};
    req.rs1 <= rs1;
    req_valid <= 1'b1;
    waited = 0;
    do begin
      @(posedge nice_clk);
      waited++;
      if (waited > timeout_cycles) begin
        give_up("req_ready to accept the instruction");
      end
      check_value("active with a request pending", active, 1'b1);
    end while (!req_ready);
    req_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge nice_clk);
      waited++;
      if (waited > timeout_cycles) begin
        give_up("rsp_valid after the instruction");
      end
      check_value("active while not idle", active, 1'b1);
      if (busy_check && !rsp_valid) begin
        check_value("mem_holdup while busy", mem_holdup, 1'b1);
        check_value("req_ready while busy", req_ready, 1'b0);
      end
    end while (!rsp_valid);
    cycles = waited;
    // Late rsp_ready while the response must stay up
    hold = stall_en ? ($urandom % 4) : 0;
    repeat (hold) begin
      @(posedge nice_clk);
      check_value("rsp_valid held until taken", rsp_valid, 1'b1);
    end
    rsp_ready <= 1'b1;
    @(posedge nice_clk);
    check_value("rsp_valid at handshake", rsp_valid, 1'b1);
    check_value("response err", rsp.err, exp_err);
    rsp_ready <= 1'b0;
  endtask

  task automatic check_reads(input logic [31:0] base, input int count);
    check_value("number of reads", rd_addr_q.size(), count);
    for (int n = 0; n < count; n++) begin
      check_value("read address", rd_addr_q[n], base + `NICE_WORD_BYTES * n);
    end
    check_value("writes during a load", wr_addr_q.size(), 0);
  endtask

  task automatic check_writes;
    check_value("number of writes", wr_addr_q.size(), c_words);
    for (int n = 0; n < c_words; n++) begin
      check_value("write address", wr_addr_q[n], c_base + `NICE_WORD_BYTES * n);
      check_value("C word", wr_data_q[n], stim[c_off+n]);
    end
    check_value("reads during calc", rd_addr_q.size(), 0);
  endtask

  // Load A, Load B then Calc
  task automatic run_matrix_sequence;
    int cycles;
    clear_logs();
    run_instr(`NICE_F7_LOADA, a_base, 1'b0, 1'b1, cycles);
    check_reads(a_base, a_words);
    clear_logs();
    run_instr(`NICE_F7_LOADB, b_base, 1'b0, 1'b0, cycles);
    check_reads(b_base, c_words);
    clear_logs();
    run_instr(`NICE_F7_CALC, c_base, 1'b0, 1'b1, cycles);
    check_writes();
  endtask

  initial begin
    int waited;
    word_t acc;
    req_valid <= 1'b0;
    req <= '0;
    rsp_ready <= 1'b0;
    icb_cmd_ready <= 1'b0;
    icb_rsp_valid <= 1'b0;
    icb_rsp <= '0;
    void'($urandom(32'hdfc7_5ef2));
    $readmemh("verif/nice_mm_input.txt", stim);
    a_base = stim[0];
    b_base = stim[1];
    c_base = stim[2];
    for (int n = 0; n < a_words; n++) begin
      mem[a_base + `NICE_WORD_BYTES * n] = stim[a_off+n];
    end
    for (int n = 0; n < c_words; n++) begin
      mem[b_base + `NICE_WORD_BYTES * n] = stim[b_off+n];
    end

    // File C must match C[i][j] = sum over k of B[i][k] * A[k][j]
    for (int i = 0; i < `NICE_B_ROWS; i++) begin
      for (int j = 0; j < dim; j++) begin
        acc = '0;
        for (int k = 0; k < dim; k++) begin
          acc += stim[b_off + i*dim + k] * stim[a_off + k*dim + j];
        end
        check_value("file C against B x A", acc, stim[c_off + i*dim + j]);
      end
    end

    waited = 0;
    while (nice_rst_n !== 1'b1) begin
      @(posedge nice_clk);
      waited++;
      if (waited > timeout_cycles) begin
        give_up("reset release");
      end
    end
    check_value("req_ready after reset", req_ready, 1'b1);
    check_value("rsp_valid after reset", rsp_valid, 1'b0);
    check_value("icb_cmd_valid after reset", icb_cmd_valid, 1'b0);
    check_value("mem_holdup after reset", mem_holdup, 1'b0);
    check_value("active when idle without a request", active, 1'b0);

    // Clean run and then the same under stalls and latency
    run_matrix_sequence();
    stall_en = 1'b1;
    run_matrix_sequence();

    // Injected read error shows in err
    clear_logs();
    inject_idx = stim[3];
    run_instr(`NICE_F7_LOADA, a_base, 1'b1, 1'b1, rsp_cycles);
    inject_idx = -1;

    // Unknown func7 is answered next cycle with no memory traffic
    clear_logs();
    run_instr(7'b0111111, a_base, 1'b1, 1'b0, rsp_cycles);
    check_value("cycles to unsupported response", rsp_cycles, 1);
    check_value("memory commands for unsupported", cmd_seen, 1'b0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/nice_mm_input.txt */
// Line 1: A base, B base, C base, read index of the error test (reads counted from 0)
// Then A (16 words), B (12 words), expected C = B x A (12 words), row-major, signed hex
00001000 00002040 00003080 00000005
// Matrix A, one row per line
00000001 00000002 ffffffff 00000003
00000000 fffffffe 00000004 00000001
00000005 00000001 00000000 fffffffd
00000002 ffffffff 00000003 00000002
// Matrix B, one row per line
00000001 00000002 00000003 00000004
ffffffff 00000000 00000002 fffffffe
00000003 fffffffd 00000001 00000000
// Expected C, one row per line
00000018 fffffffd 00000013 00000004
00000005 00000002 fffffffb fffffff3
00000008 0000000d fffffff1 00000003

/* vlog.f */
+incdir+rtl
rtl/nice_mm_pkg.sv
rtl/nice_mm_pe.sv
rtl/nice_mm_array.sv
rtl/nice_mm_datapath.sv
rtl/nice_mm_ctrl.sv
rtl/nice_mm_top.sv
verif/nice_mm_clkgen.sv
verif/nice_mm_assertions.sv
verif/nice_mm_tb.sv

/* Makefile */
# Verilator simulation of the NICE matrix coprocessor

VERILATOR ?= verilator
TOP       ?= nice_mm_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, and pass only if the output holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
